// File: rtl/nvme_queue_pkg.sv
`default_nettype none

package nvme_queue_pkg;

	localparam int NUM_QUEUES  = 9; // admin + 8 io
	localparam int NUM_VECTORS = 8;
	localparam int QPTR_W      = 8;
	localparam int QID_W       = 4;
	localparam int IV_W        = 3;

	typedef logic [QPTR_W-1:0] qptr_t;
	typedef logic [QID_W-1:0] qid_t; // 0 = admin queue
	typedef logic [IV_W-1:0] irq_vec_t;
	typedef logic [NUM_VECTORS-1:0] vec_mask_t;
	typedef logic [NUM_QUEUES-1:0] q_bits_t;

	typedef qptr_t [NUM_QUEUES-1:0] qptr_array_t;

	// size is the highest slot index, not the slot count
	typedef struct packed {
		logic  valid;
		qptr_t size;
	} sq_cfg_t;

	typedef struct packed {
		logic     valid;
		logic     irq_en;
		irq_vec_t iv;
		qptr_t    size;
	} cq_cfg_t;

	typedef sq_cfg_t [NUM_QUEUES-1:0] sq_cfg_array_t;
	typedef cq_cfg_t [NUM_QUEUES-1:0] cq_cfg_array_t;

	// one host doorbell write
	typedef struct packed {
		logic  is_cq; // 1 = cq head, 0 = sq tail
		qid_t  qid;
		qptr_t ptr;
	} doorbell_t;

	typedef enum logic [1:0] {
		MSI_IDLE,
		MSI_SEND,
		MSI_WAIT
	} msi_state_t;

endpackage

`default_nettype wire

// File: rtl/doorbell_regs.sv
`timescale 1ns/1ns
`default_nettype none

module doorbell_regs
	import nvme_queue_pkg::*;
(
	input  wire logic          pcie_user_clk,
	input  wire logic          pcie_user_rst_n,

	input  wire logic          db_wr_en,
	input  wire doorbell_t     db_wr,

	input  wire logic          intms_wr_en,
	input  wire logic          intmc_wr_en,
	input  wire vec_mask_t     intm_data,

	input  wire sq_cfg_array_t sq_cfg,
	input  wire cq_cfg_array_t cq_cfg,

	output logic               db_err,
	output qptr_array_t        sq_tail,
	output qptr_array_t        cq_head,
	output q_bits_t            cq_head_update,
	output vec_mask_t          irq_mask
);

	logic  qid_ok;
	logic  sel_valid;
	qptr_t sel_size;
	logic  db_ok;
	logic  db_sq_wr;
	logic  db_cq_wr;

	// look up the addressed queue's config
	always_comb begin
		qid_ok    = db_wr.qid < NUM_QUEUES;
		sel_valid = 1'b0;
		sel_size  = '0;
		if (qid_ok) begin
			if (db_wr.is_cq) begin
				sel_valid = cq_cfg[db_wr.qid].valid;
				sel_size  = cq_cfg[db_wr.qid].size;
			end else begin
				sel_valid = sq_cfg[db_wr.qid].valid;
				sel_size  = sq_cfg[db_wr.qid].size;
			end
		end
		db_ok    = qid_ok && sel_valid && (db_wr.ptr <= sel_size);
		db_sq_wr = db_wr_en && db_ok && !db_wr.is_cq;
		db_cq_wr = db_wr_en && db_ok && db_wr.is_cq;
	end

	always_ff @(posedge pcie_user_clk) begin
		if (!pcie_user_rst_n) begin
			db_err         <= 1'b0;
			sq_tail        <= '0;
			cq_head        <= '0;
			cq_head_update <= '0;
		end else begin
			db_err <= db_wr_en && !db_ok; // one cycle per rejected write
			for (int q = 0; q < NUM_QUEUES; q++) begin
				cq_head_update[q] <= db_cq_wr && (db_wr.qid == QID_W'(q));

				if (!sq_cfg[q].valid)
					sq_tail[q] <= '0; // queue deleted or not yet created
				else if (db_sq_wr && (db_wr.qid == QID_W'(q)))
					sq_tail[q] <= db_wr.ptr;

				if (!cq_cfg[q].valid)
					cq_head[q] <= '0;
				else if (db_cq_wr && (db_wr.qid == QID_W'(q)))
					cq_head[q] <= db_wr.ptr;
			end
		end
	end

	// INTMS / INTMC, set beats clear on a collision
	always_ff @(posedge pcie_user_clk) begin
		if (!pcie_user_rst_n)
			irq_mask <= '0;
		else if (intms_wr_en || intmc_wr_en)
			irq_mask <= (irq_mask & ~(intmc_wr_en ? intm_data : '0))
				| (intms_wr_en ? intm_data : '0);
	end

endmodule

`default_nettype wire

// File: rtl/cq_tail_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module cq_tail_tracker
	import nvme_queue_pkg::*;
(
	input  wire logic          pcie_user_clk,
	input  wire logic          pcie_user_rst_n,

	input  wire logic          cpl_post_en,
	input  wire qid_t          cpl_post_qid,

	input  wire cq_cfg_array_t cq_cfg,
	input  wire qptr_array_t   cq_head,

	output qptr_array_t        cq_tail,
	output logic               cpl_post_full
);

	cq_cfg_t sel_cfg;
	qptr_t   sel_tail;
	qptr_t   sel_head;
	qptr_t   tail_next;
	logic    post_ok;

	always_comb begin
		sel_cfg  = '0; // unknown qid reads as an invalid queue
		sel_tail = '0;
		sel_head = '0;
		if (cpl_post_qid < NUM_QUEUES) begin
			sel_cfg  = cq_cfg[cpl_post_qid];
			sel_tail = cq_tail[cpl_post_qid];
			sel_head = cq_head[cpl_post_qid];
		end

		// wrap after the last slot
		if (sel_tail == sel_cfg.size)
			tail_next = '0;
		else
			tail_next = sel_tail + 1'b1;

		// one slot stays empty so full and empty differ
		cpl_post_full = !sel_cfg.valid || (tail_next == sel_head);
		post_ok       = cpl_post_en && !cpl_post_full;
	end

	always_ff @(posedge pcie_user_clk) begin
		if (!pcie_user_rst_n) begin
			cq_tail <= '0;
		end else begin
			for (int q = 0; q < NUM_QUEUES; q++) begin
				if (!cq_cfg[q].valid)
					cq_tail[q] <= '0;
				else if (post_ok && (cpl_post_qid == QID_W'(q)))
					cq_tail[q] <= tail_next;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/msi_irq_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module msi_irq_ctrl
	import nvme_queue_pkg::*;
(
	input  wire logic          pcie_user_clk,
	input  wire logic          pcie_user_rst_n,

	input  wire cq_cfg_array_t cq_cfg,
	input  wire qptr_array_t   cq_head,
	input  wire qptr_array_t   cq_tail,
	input  wire q_bits_t       cq_head_update,

	input  wire vec_mask_t     irq_mask,
	input  wire logic          msi_enable,

	input  wire logic          cfg_interrupt_msi_sent,
	input  wire logic          cfg_interrupt_msi_fail,
	output vec_mask_t          cfg_interrupt_msi_int
);

	q_bits_t    cq_active;
	vec_mask_t  vec_req;
	vec_mask_t  vec_clr;
	vec_mask_t  vec_set;
	vec_mask_t  vec_pend;
	vec_mask_t  signaled;
	vec_mask_t  sel_onehot;
	msi_state_t state;
	irq_vec_t   sel_vec;

	// lowest set bit wins
	function automatic irq_vec_t lowest_vec(input vec_mask_t req);
		irq_vec_t v;
		v = '0;
		for (int i = NUM_VECTORS - 1; i >= 0; i--) begin
			if (req[i])
				v = irq_vec_t'(i);
		end
		return v;
	endfunction

	// fold per-cq state onto vectors
	always_comb begin
		vec_req = '0;
		vec_clr = '0;
		for (int q = 0; q < NUM_QUEUES; q++) begin
			cq_active[q] = cq_cfg[q].valid && cq_cfg[q].irq_en
				&& (cq_head[q] != cq_tail[q]);
			if (cq_active[q])
				vec_req[cq_cfg[q].iv] = 1'b1;
			if (cq_head_update[q])
				vec_clr[cq_cfg[q].iv] = 1'b1; // host consumed, rearm
		end
		vec_pend = vec_req & ~irq_mask & ~signaled & {NUM_VECTORS{msi_enable}};
	end

	always_comb begin
		sel_onehot = vec_mask_t'(1) << sel_vec;
		vec_set    = '0;
		if (state == MSI_WAIT && cfg_interrupt_msi_sent)
			vec_set = sel_onehot;
		cfg_interrupt_msi_int = (state == MSI_SEND) ? sel_onehot : '0;
	end

	always_ff @(posedge pcie_user_clk) begin
		if (!pcie_user_rst_n) begin
			state    <= MSI_IDLE;
			signaled <= '0;
		end else begin
			// a head write in the same cycle as sent still rearms
			signaled <= (signaled | vec_set) & ~vec_clr;
			case (state)
				MSI_IDLE: begin
					if (|vec_pend)
						state <= MSI_SEND;
				end
				MSI_SEND: begin
					state <= MSI_WAIT; // int held one cycle only
				end
				MSI_WAIT: begin
					if (cfg_interrupt_msi_sent || cfg_interrupt_msi_fail)
						state <= MSI_IDLE; // fail leaves it pending, retried
				end
				default: begin
					state <= MSI_IDLE;
				end
			endcase
		end
	end

	// vector stays put through send and wait
	always_ff @(posedge pcie_user_clk) begin
		if (state == MSI_IDLE)
			sel_vec <= lowest_vec(vec_pend);
	end

endmodule

`default_nettype wire

// File: rtl/nvme_queue_top.sv
`timescale 1ns/1ns
`default_nettype none

module nvme_queue_top
	import nvme_queue_pkg::*;
(
	input  wire logic          pcie_user_clk,
	input  wire logic          pcie_user_rst_n,

	input  wire logic          db_wr_en,
	input  wire doorbell_t     db_wr,
	input  wire logic          intms_wr_en,
	input  wire logic          intmc_wr_en,
	input  wire vec_mask_t     intm_data,

	input  wire logic          cpl_post_en,
	input  wire qid_t          cpl_post_qid,

	input  wire sq_cfg_array_t sq_cfg,
	input  wire cq_cfg_array_t cq_cfg,
	input  wire logic          msi_enable,

	input  wire logic          cfg_interrupt_msi_sent,
	input  wire logic          cfg_interrupt_msi_fail,

	output logic               db_err,
	output logic               cpl_post_full,
	output qptr_array_t        sq_tail,
	output qptr_array_t        cq_tail,
	output vec_mask_t          cfg_interrupt_msi_int
);

	qptr_array_t cq_head;
	q_bits_t     cq_head_update;
	vec_mask_t   irq_mask;

	doorbell_regs doorbell_regs_i (
		.pcie_user_clk   (pcie_user_clk),
		.pcie_user_rst_n (pcie_user_rst_n),
		.db_wr_en        (db_wr_en),
		.db_wr           (db_wr),
		.intms_wr_en     (intms_wr_en),
		.intmc_wr_en     (intmc_wr_en),
		.intm_data       (intm_data),
		.sq_cfg          (sq_cfg),
		.cq_cfg          (cq_cfg),
		.db_err          (db_err),
		.sq_tail         (sq_tail),
		.cq_head         (cq_head),
		.cq_head_update  (cq_head_update),
		.irq_mask        (irq_mask)
	);

	cq_tail_tracker cq_tail_tracker_i (
		.pcie_user_clk   (pcie_user_clk),
		.pcie_user_rst_n (pcie_user_rst_n),
		.cpl_post_en     (cpl_post_en),
		.cpl_post_qid    (cpl_post_qid),
		.cq_cfg          (cq_cfg),
		.cq_head         (cq_head),
		.cq_tail         (cq_tail),
		.cpl_post_full   (cpl_post_full)
	);

	msi_irq_ctrl msi_irq_ctrl_i (
		.pcie_user_clk          (pcie_user_clk),
		.pcie_user_rst_n        (pcie_user_rst_n),
		.cq_cfg                 (cq_cfg),
		.cq_head                (cq_head),
		.cq_tail                (cq_tail),
		.cq_head_update         (cq_head_update),
		.irq_mask               (irq_mask),
		.msi_enable             (msi_enable),
		.cfg_interrupt_msi_sent (cfg_interrupt_msi_sent),
		.cfg_interrupt_msi_fail (cfg_interrupt_msi_fail),
		.cfg_interrupt_msi_int  (cfg_interrupt_msi_int)
	);

endmodule

`default_nettype wire

// File: include/tb_nvme_queue_table.svh
`ifndef TB_NVME_QUEUE_TABLE_SVH
`define TB_NVME_QUEUE_TABLE_SVH

// each row is op, qid, ptr, data, exp
// ptr doubles as queue size for config rows and as cycle count for waits
// cq config data has valid in bit 7, irq_en in bit 6 and iv in bits 2..0
// exp is the expected db_err for doorbells, cpl_post_full for posts

localparam int NUM_ROWS = 47;

row_t rows [NUM_ROWS] = '{
	'{OP_CFG_SQ,   4'd0, 8'd7,  8'h80, 1'b0},
	'{OP_CFG_CQ,   4'd0, 8'd3,  8'hc0, 1'b0}, // admin cq on vector 0
	'{OP_CFG_SQ,   4'd1, 8'd15, 8'h80, 1'b0},
	'{OP_CFG_CQ,   4'd1, 8'd3,  8'hc1, 1'b0},
	'{OP_CFG_CQ,   4'd2, 8'd7,  8'hc2, 1'b0},
	'{OP_DB_SQ,    4'd0, 8'd5,  8'h00, 1'b0},
	'{OP_DB_SQ,    4'd1, 8'd15, 8'h00, 1'b0}, // exactly at size
	'{OP_DB_SQ,    4'd0, 8'd8,  8'h00, 1'b1},
	'{OP_DB_SQ,    4'd2, 8'd1,  8'h00, 1'b1}, // sq 2 never created
	'{OP_DB_CQ,    4'd3, 8'd0,  8'h00, 1'b1},
	'{OP_DB_SQ,    4'd9, 8'd0,  8'h00, 1'b1}, // qid out of range
	'{OP_DB_CQ,    4'd1, 8'd4,  8'h00, 1'b1},
	'{OP_POST,     4'd1, 8'd0,  8'h00, 1'b0},
	'{OP_MSI,      4'd0, 8'd0,  8'h00, 1'b0},
	'{OP_POST,     4'd1, 8'd0,  8'h00, 1'b0},
	'{OP_POST,     4'd1, 8'd0,  8'h00, 1'b0},
	'{OP_POST,     4'd1, 8'd0,  8'h00, 1'b1}, // tail+1 hits head
	'{OP_WAIT,     4'd0, 8'd30, 8'h00, 1'b0},
	'{OP_DB_CQ,    4'd1, 8'd2,  8'h00, 1'b0}, // still non-empty, rearms
	'{OP_MSI,      4'd0, 8'd0,  8'h00, 1'b0},
	'{OP_POST,     4'd1, 8'd0,  8'h00, 1'b0}, // wraps to 0
	'{OP_POST,     4'd1, 8'd0,  8'h00, 1'b0},
	'{OP_POST,     4'd1, 8'd0,  8'h00, 1'b1},
	'{OP_DB_CQ,    4'd1, 8'd1,  8'h00, 1'b0},
	'{OP_WAIT,     4'd0, 8'd20, 8'h00, 1'b0},
	'{OP_MASK_SET, 4'd0, 8'd0,  8'h06, 1'b0},
	'{OP_POST,     4'd2, 8'd0,  8'h00, 1'b0},
	'{OP_POST,     4'd1, 8'd0,  8'h00, 1'b0},
	'{OP_WAIT,     4'd0, 8'd20, 8'h00, 1'b0},
	'{OP_MASK_CLR, 4'd0, 8'd0,  8'h06, 1'b0},
	'{OP_MSI,      4'd0, 8'd0,  8'h00, 1'b0}, // vector 1 first
	'{OP_MSI,      4'd0, 8'd0,  8'h00, 1'b0},
	'{OP_POST,     4'd0, 8'd0,  8'h00, 1'b0},
	'{OP_MSI,      4'd0, 8'd0,  8'h00, 1'b0}, // answered with fail
	'{OP_MSI,      4'd0, 8'd0,  8'h00, 1'b0},
	'{OP_CFG_CQ,   4'd3, 8'd3,  8'h83, 1'b0}, // valid but irq_en low
	'{OP_POST,     4'd3, 8'd0,  8'h00, 1'b0},
	'{OP_WAIT,     4'd0, 8'd20, 8'h00, 1'b0},
	'{OP_MSI_EN,   4'd0, 8'd0,  8'h00, 1'b0},
	'{OP_DB_CQ,    4'd0, 8'd1,  8'h00, 1'b0},
	'{OP_DB_CQ,    4'd2, 8'd1,  8'h00, 1'b0},
	'{OP_POST,     4'd2, 8'd0,  8'h00, 1'b0},
	'{OP_WAIT,     4'd0, 8'd30, 8'h00, 1'b0},
	'{OP_CFG_SQ,   4'd1, 8'd15, 8'h00, 1'b0}, // delete sq 1
	'{OP_CFG_CQ,   4'd1, 8'd3,  8'h41, 1'b0},
	'{OP_POST,     4'd1, 8'd0,  8'h00, 1'b1},
	'{OP_DB_SQ,    4'd1, 8'd0,  8'h00, 1'b1}
};

`endif

// File: tests/tb_nvme_queue.sv
`timescale 1ns/1ns
`default_nettype none

module tb_nvme_queue
	import nvme_queue_pkg::*;
();

	typedef enum logic [3:0] {
		OP_CFG_SQ, OP_CFG_CQ, OP_MSI_EN, OP_DB_SQ, OP_DB_CQ,
		OP_POST, OP_MASK_SET, OP_MASK_CLR, OP_WAIT, OP_MSI
	} op_t;

	typedef struct packed {
		op_t        op;
		qid_t       qid;
		qptr_t      ptr;
		logic [7:0] data;
		logic       exp;
	} row_t;

	localparam int FAIL_AT = 5; // msi number that gets a fail answer

	`include "tb_nvme_queue_table.svh"

	logic          pcie_user_clk, pcie_user_rst_n;
	logic          db_wr_en, intms_wr_en, intmc_wr_en, cpl_post_en, msi_enable;
	logic          cfg_interrupt_msi_sent, cfg_interrupt_msi_fail;
	logic          db_err, cpl_post_full;
	doorbell_t     db_wr;
	vec_mask_t     intm_data, cfg_interrupt_msi_int;
	qid_t          cpl_post_qid;
	sq_cfg_array_t sq_cfg;
	cq_cfg_array_t cq_cfg;
	qptr_array_t   sq_tail, cq_tail;

	qptr_array_t   m_sq_tail, m_cq_head, m_cq_tail; // reference model
	vec_mask_t     m_mask, m_signaled;
	int            msi_cnt = 0;
	int            msi_used = 0;
	vec_mask_t     msi_vec_log [$];
	logic          msi_fail_log [$];

	nvme_queue_top dut_i (.*);

	initial pcie_user_clk = 1'b0;
	always #20 pcie_user_clk = ~pcie_user_clk;

	task automatic report_error(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] next_rand(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic qptr_t next_slot(input qptr_t p, input qptr_t size);
		return (p == size) ? '0 : p + 1'b1;
	endfunction

	// lowest vector the model says must be signaled next, -1 if none
	function automatic int expected_vector();
		vec_mask_t req;
		vec_mask_t pend;
		int        v;
		req = '0;
		v   = -1;
		for (int q = 0; q < NUM_QUEUES; q++) begin
			if (cq_cfg[q].valid && cq_cfg[q].irq_en && m_cq_head[q] != m_cq_tail[q])
				req[cq_cfg[q].iv] = 1'b1;
		end
		pend = req & ~m_mask & ~m_signaled & {NUM_VECTORS{msi_enable}};
		for (int i = NUM_VECTORS - 1; i >= 0; i--) begin
			if (pend[i])
				v = i;
		end
		return v;
	endfunction

	task automatic take_msi();
		int        exp_v;
		vec_mask_t vec;
		logic      failed;
		while (msi_vec_log.size() == 0)
			@(negedge pcie_user_clk);
		exp_v  = expected_vector();
		vec    = msi_vec_log.pop_front();
		failed = msi_fail_log.pop_front();
		msi_used++;
		assert (exp_v >= 0 && vec == (vec_mask_t'(1) << exp_v)) else
			report_error($sformatf("MSI %b, expected vector %0d", vec, exp_v));
		if (!failed)
			m_signaled = m_signaled | vec;
		@(posedge pcie_user_clk);
		#5;
	endtask

	task automatic apply_row(input row_t r);
		int    q;
		logic  ok;
		qptr_t nxt;
		q   = int'(r.qid);
		ok  = 1'b0;
		nxt = '0;
		case (r.op)
			OP_CFG_SQ: sq_cfg[q] = {r.data[7], r.ptr};
			OP_CFG_CQ: cq_cfg[q] = {r.data[7], r.data[6], r.data[2:0], r.ptr};
			OP_MSI_EN: msi_enable = r.data[0];
			OP_DB_SQ, OP_DB_CQ: begin
				db_wr_en = 1'b1;
				db_wr    = {r.op == OP_DB_CQ, r.qid, r.ptr};
				if (q < NUM_QUEUES && r.op == OP_DB_CQ)
					ok = cq_cfg[q].valid && r.ptr <= cq_cfg[q].size;
				else if (q < NUM_QUEUES)
					ok = sq_cfg[q].valid && r.ptr <= sq_cfg[q].size;
			end
			OP_POST: begin
				cpl_post_en  = 1'b1;
				cpl_post_qid = r.qid;
				nxt = next_slot(m_cq_tail[q], cq_cfg[q].size);
				ok  = cq_cfg[q].valid && nxt != m_cq_head[q];
			end
			OP_MASK_SET: begin
				intms_wr_en = 1'b1;
				intm_data   = r.data;
			end
			OP_MASK_CLR: begin
				intmc_wr_en = 1'b1;
				intm_data   = r.data;
			end
			default: ;
		endcase
		@(negedge pcie_user_clk);
		if (r.op == OP_POST)
			assert (cpl_post_full == r.exp) else
				report_error($sformatf("cpl_post_full %0b on cq %0d", cpl_post_full, q));
		@(posedge pcie_user_clk);
		#5;
		db_wr_en    = 1'b0;
		cpl_post_en = 1'b0;
		intms_wr_en = 1'b0;
		intmc_wr_en = 1'b0;
		if (r.op == OP_DB_SQ || r.op == OP_DB_CQ)
			assert (db_err == r.exp) else
				report_error($sformatf("db_err %0b on qid %0d ptr %0d", db_err, q, r.ptr));
		case (r.op)
			OP_CFG_SQ: if (!r.data[7]) m_sq_tail[q] = '0;
			OP_CFG_CQ: if (!r.data[7]) begin
				m_cq_head[q] = '0;
				m_cq_tail[q] = '0;
			end
			OP_DB_SQ: if (ok) m_sq_tail[q] = r.ptr;
			OP_DB_CQ: if (ok) begin
				m_cq_head[q] = r.ptr;
				m_signaled[cq_cfg[q].iv] = 1'b0; // head moved, vector rearmed
			end
			OP_POST: if (ok) m_cq_tail[q] = nxt;
			OP_MASK_SET: m_mask = m_mask | r.data;
			OP_MASK_CLR: m_mask = m_mask & ~r.data;
			OP_WAIT: begin
				repeat (r.ptr) @(posedge pcie_user_clk);
				#5;
			end
			OP_MSI: take_msi();
			default: ;
		endcase
	endtask

	initial begin : table_run
		pcie_user_rst_n        = 1'b0;
		db_wr_en               = 1'b0;
		db_wr                  = '0;
		intms_wr_en            = 1'b0;
		intmc_wr_en            = 1'b0;
		intm_data              = '0;
		cpl_post_en            = 1'b0;
		cpl_post_qid           = '0;
		sq_cfg                 = '0;
		cq_cfg                 = '0;
		msi_enable             = 1'b1;
		cfg_interrupt_msi_sent = 1'b0;
		cfg_interrupt_msi_fail = 1'b0;
		m_sq_tail              = '0;
		m_cq_head              = '0;
		m_cq_tail              = '0;
		m_mask                 = '0;
		m_signaled             = '0;
		repeat (10) @(posedge pcie_user_clk);
		#5;
		pcie_user_rst_n = 1'b1;
		for (int i = 0; i < NUM_ROWS; i++) begin
			apply_row(rows[i]);
			assert (sq_tail == m_sq_tail) else
				report_error($sformatf("row %0d sq_tail %h, expected %h", i, sq_tail, m_sq_tail));
			assert (cq_tail == m_cq_tail) else
				report_error($sformatf("row %0d cq_tail %h, expected %h", i, cq_tail, m_cq_tail));
			if (rows[i].op != OP_MSI)
				assert (msi_cnt == msi_used) else
					report_error($sformatf("row %0d unexpected MSI, count %0d", i, msi_cnt));
		end
		$display("Regression passed");
		$finish;
	end

	// stands in for the PCIe core
	initial begin : msi_responder
		logic [31:0] rng;
		int          delay;
		vec_mask_t   vec;
		rng = 32'd55119;
		forever begin
			@(negedge pcie_user_clk);
			if (cfg_interrupt_msi_int != '0) begin
				vec = cfg_interrupt_msi_int;
				msi_cnt++;
				assert ($onehot(vec)) else report_error($sformatf("MSI %b not one-hot", vec));
				@(negedge pcie_user_clk);
				assert (cfg_interrupt_msi_int == '0) else
					report_error("MSI held for more than one cycle");
				rng   = next_rand(rng);
				delay = int'(rng % 32'd8) + 1;
				repeat (delay) @(posedge pcie_user_clk);
				#5;
				cfg_interrupt_msi_fail = (msi_cnt == FAIL_AT);
				cfg_interrupt_msi_sent = (msi_cnt != FAIL_AT);
				@(posedge pcie_user_clk);
				#5;
				cfg_interrupt_msi_sent = 1'b0;
				cfg_interrupt_msi_fail = 1'b0;
				msi_vec_log.push_back(vec);
				msi_fail_log.push_back(msi_cnt == FAIL_AT);
			end
		end
	end

	initial begin : watchdog
		repeat (NUM_ROWS * 40 + 10) @(posedge pcie_user_clk);
		$display("Watchdog timeout, the table did not finish in %0d cycles", NUM_ROWS * 40 + 10);
		$display("Regression failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
rtl/nvme_queue_pkg.sv
rtl/doorbell_regs.sv
rtl/cq_tail_tracker.sv
rtl/msi_irq_ctrl.sv
rtl/nvme_queue_top.sv
tests/tb_nvme_queue.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_nvme_queue -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_nvme_queue)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	exit 1
fi

if echo "$out" | grep -q "^Regression passed$"; then
	exit 0
fi
exit 1
